// File: btn_debounce.sv
`timescale 1ns/1ps

module btn_debounce (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic btn,
    output logic level,
    output logic press
);

    logic                            sync_0;
    logic                            sync_1;
    frog_pkg::deb_state_t            state;
    logic [frog_pkg::DEB_CNT_W-1:0]  stable_cnt;
    logic                            cnt_full;

    // Two-flop synchronizer for the raw button
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sync_0 <= 1'b0;
            sync_1 <= 1'b0;
        end else begin
            sync_0 <= btn;
            sync_1 <= sync_0;
        end
    end

    assign cnt_full = (stable_cnt == frog_pkg::DEB_CNT_W'(frog_pkg::DEBOUNCE_CYCLES - 1));

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state      <= frog_pkg::IDLE_LOW;
            stable_cnt <= '0;
            level      <= 1'b0;
            press      <= 1'b0;
        end else begin
            // Pulse only in the cycle the level goes high
            press <= 1'b0;
            case (state)
                frog_pkg::IDLE_LOW: begin
                    stable_cnt <= '0;
                    if (sync_1) begin
                        state <= frog_pkg::WAIT_HIGH;
                    end
                end
                frog_pkg::WAIT_HIGH: begin
                    if (!sync_1) begin
                        state <= frog_pkg::IDLE_LOW;
                    end else if (cnt_full) begin
                        state <= frog_pkg::IDLE_HIGH;
                        level <= 1'b1;
                        press <= 1'b1;
                    end else begin
                        stable_cnt <= stable_cnt + 1'b1;
                    end
                end
                frog_pkg::IDLE_HIGH: begin
                    stable_cnt <= '0;
                    if (!sync_1) begin
                        state <= frog_pkg::WAIT_LOW;
                    end
                end
                default: begin
                    // Release side gives no pulse on the falling level
                    if (sync_1) begin
                        state <= frog_pkg::IDLE_HIGH;
                    end else if (cnt_full) begin
                        state <= frog_pkg::IDLE_LOW;
                        level <= 1'b0;
                    end else begin
                        stable_cnt <= stable_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: frog_motion.sv
`timescale 1ns/1ps

module frog_motion (
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  logic                left_step,
    input  logic                right_step,
    input  logic                hop_step,
    output frog_pkg::frog_pos_t frog_pos,
    output frog_pkg::score_t    score
);

    logic at_left_wall;
    logic at_right_wall;
    logic at_goal;

    // A side move stops when no whole cell is left before the wall
    assign at_left_wall  = (frog_pos.x < frog_pkg::FIELD_X0 + frog_pkg::CELL);
    assign at_right_wall = (frog_pos.x + frog_pkg::CELL >
                            frog_pkg::FIELD_X1 - frog_pkg::FROG_SIZE);
    assign at_goal       = (frog_pos.y == frog_pkg::FIELD_Y0);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            frog_pos.x <= frog_pkg::START_X;
            frog_pos.y <= frog_pkg::START_Y;
            score      <= '0;
        end else if (hop_step) begin
            // A hop out of the goal lane counts as a crossing
            if (at_goal) begin
                frog_pos.x <= frog_pkg::START_X;
                frog_pos.y <= frog_pkg::START_Y;
                score      <= score + 1'b1;
            end else begin
                frog_pos.y <= frog_pos.y - frog_pkg::CELL;
            end
        end else if (left_step) begin
            if (!at_left_wall) begin
                frog_pos.x <= frog_pos.x - frog_pkg::CELL;
            end
        end else if (right_step) begin
            if (!at_right_wall) begin
                frog_pos.x <= frog_pos.x + frog_pkg::CELL;
            end
        end
    end

endmodule

// File: frog_pixel_gen.sv
`timescale 1ns/1ps

module frog_pixel_gen (
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  frog_pkg::pixel_t    pix,
    input  frog_pkg::frog_pos_t frog_pos,
    output logic                hsync,
    output logic                vsync,
    output frog_pkg::rgb_t      rgb
);

    logic             in_frog;
    logic             in_field;
    frog_pkg::coord_t lane_off;
    frog_pkg::coord_t lane_idx;
    frog_pkg::rgb_t   lane_color;
    frog_pkg::rgb_t   rgb_next;

    assign in_frog = (pix.x >= frog_pos.x) && (pix.x < frog_pos.x + frog_pkg::FROG_SIZE) &&
                     (pix.y >= frog_pos.y) && (pix.y < frog_pos.y + frog_pkg::FROG_SIZE);

    assign in_field = (pix.x >= frog_pkg::FIELD_X0) && (pix.x < frog_pkg::FIELD_X1) &&
                      (pix.y >= frog_pkg::FIELD_Y0) && (pix.y < frog_pkg::FIELD_Y1);

    // Lane number counted down from the goal row
    assign lane_off = pix.y - frog_pkg::FIELD_Y0;
    assign lane_idx = lane_off / frog_pkg::CELL;

    always_comb begin
        case (lane_idx) inside
            10'd0:          lane_color = frog_pkg::GOAL_COLOR;
            [10'd1:10'd5]:  lane_color = frog_pkg::RIVER_COLOR;
            10'd6:          lane_color = frog_pkg::MEDIAN_COLOR;
            [10'd7:10'd11]: lane_color = frog_pkg::ROAD_COLOR;
            default:        lane_color = frog_pkg::START_COLOR;
        endcase
    end

    // Blanking first, then the frog over the field
    always_comb begin
        if (!pix.video_on) begin
            rgb_next = '0;
        end else if (in_frog) begin
            rgb_next = frog_pkg::FROG_COLOR;
        end else if (!in_field) begin
            rgb_next = frog_pkg::WALL_COLOR;
        end else begin
            rgb_next = lane_color;
        end
    end

    // Color and syncs leave together, one pixel behind the counters
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            rgb   <= '0;
        end else if (pix.p_tick) begin
            hsync <= pix.hsync;
            vsync <= pix.vsync;
            rgb   <= rgb_next;
        end
    end

endmodule

// File: frog_pkg.sv
package frog_pkg;

    typedef logic [9:0]  coord_t;
    typedef logic [11:0] rgb_t;
    typedef logic [7:0]  score_t;

    // Top-left corner of the frog sprite
    typedef struct packed {
        coord_t x;
        coord_t y;
    } frog_pos_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   video_on;
        logic   hsync;
        logic   vsync;
        logic   p_tick;
    } pixel_t;

    typedef enum logic [1:0] {
        IDLE_LOW,
        WAIT_HIGH,
        IDLE_HIGH,
        WAIT_LOW
    } deb_state_t;

    // 640x480 at 60 Hz, 25 MHz pixel rate
    localparam coord_t H_VISIBLE = 10'd640;
    localparam coord_t H_FRONT   = 10'd16;
    localparam coord_t H_SYNC    = 10'd96;
    localparam coord_t H_BACK    = 10'd48;
    localparam coord_t H_TOTAL   = 10'd800;
    localparam coord_t V_VISIBLE = 10'd480;
    localparam coord_t V_FRONT   = 10'd10;
    localparam coord_t V_SYNC    = 10'd2;
    localparam coord_t V_BACK    = 10'd33;
    localparam coord_t V_TOTAL   = 10'd525;

    localparam int PIX_DIV         = 4;
    localparam int DIV_W           = $clog2(PIX_DIV);
    localparam int DEBOUNCE_CYCLES = 16;
    localparam int DEB_CNT_W       = $clog2(DEBOUNCE_CYCLES);

    // Playing field, thirteen lanes of one cell each
    localparam coord_t FIELD_X0  = 10'd64;
    localparam coord_t FIELD_X1  = 10'd576;
    localparam coord_t FIELD_Y0  = 10'd32;
    localparam coord_t CELL      = 10'd32;
    localparam int     NUM_LANES = 13;
    localparam coord_t FIELD_Y1  = 10'(FIELD_Y0 + NUM_LANES * CELL);

    localparam coord_t FROG_SIZE = 10'd32;
    localparam coord_t START_X   = 10'd304;
    localparam coord_t START_Y   = 10'd416;

    localparam rgb_t WALL_COLOR   = 12'h444;
    localparam rgb_t GOAL_COLOR   = 12'h0A0;
    localparam rgb_t RIVER_COLOR  = 12'h00F;
    localparam rgb_t MEDIAN_COLOR = 12'h880;
    localparam rgb_t ROAD_COLOR   = 12'h222;
    localparam rgb_t START_COLOR  = 12'h880;
    localparam rgb_t FROG_COLOR   = 12'h0F0;

endpackage

// File: frog_sva.sv
`timescale 1ns/1ps

module frog_sva (
    input logic                sys_clk,
    input logic                sys_rst_n,
    input logic                left_step,
    input logic                right_step,
    input logic                hop_step,
    input logic                hsync,
    input frog_pkg::frog_pos_t frog_pos
);

    logic [15:0] hs_low_cnt;

    // Length of the current hsync low run
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            hs_low_cnt <= '0;
        end else if (!hsync) begin
            hs_low_cnt <= hs_low_cnt + 1'b1;
        end else begin
            hs_low_cnt <= '0;
        end
    end

    left_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        left_step |=> !left_step) else $error("left_step high for more than one cycle");

    right_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        right_step |=> !right_step) else $error("right_step high for more than one cycle");

    hop_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        hop_step |=> !hop_step) else $error("hop_step high for more than one cycle");

    hsync_width: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $rose(hsync) |-> (hs_low_cnt == 16'(frog_pkg::PIX_DIV * frog_pkg::H_SYNC)))
        else $error("hsync low width is not one sync interval");

    // Frog box stays between the side walls
    frog_x_bounds: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (frog_pos.x >= frog_pkg::FIELD_X0) &&
        (frog_pos.x <= frog_pkg::FIELD_X1 - frog_pkg::FROG_SIZE))
        else $error("frog x left the field");

endmodule

bind frog_top frog_sva u_sva (.*);

// File: frog_top.sv
`timescale 1ns/1ps

module frog_top (
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  logic                left_btn,
    input  logic                right_btn,
    input  logic                hop_btn,
    output logic                hsync,
    output logic                vsync,
    output frog_pkg::rgb_t      rgb,
    output frog_pkg::frog_pos_t frog_pos,
    output frog_pkg::score_t    score
);

    logic             left_step;
    logic             right_step;
    logic             hop_step;
    frog_pkg::pixel_t pix;

    // Button front end, level outputs kept for hold-to-repeat
    btn_debounce u_left_deb (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .btn       (left_btn),
        .level     (),
        .press     (left_step)
    );

    btn_debounce u_right_deb (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .btn       (right_btn),
        .level     (),
        .press     (right_step)
    );

    btn_debounce u_hop_deb (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .btn       (hop_btn),
        .level     (),
        .press     (hop_step)
    );

    frog_motion u_motion (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .left_step  (left_step),
        .right_step (right_step),
        .hop_step   (hop_step),
        .frog_pos   (frog_pos),
        .score      (score)
    );

    vga_timing u_timing (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .pix       (pix)
    );

    frog_pixel_gen u_pixel (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .pix       (pix),
        .frog_pos  (frog_pos),
        .hsync     (hsync),
        .vsync     (vsync),
        .rgb       (rgb)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the output
verilator --binary --timing --assert -f tb.f --top-module tb_frog -o sim_tb_frog &&
    ./obj_dir/sim_tb_frog | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
    echo "run.sh: simulation passed" ||
    { echo "run.sh: simulation failed"; exit 1; }

// File: tb.f
frog_pkg.sv
btn_debounce.sv
frog_motion.sv
vga_timing.sv
frog_pixel_gen.sv
frog_top.sv
frog_sva.sv
tb_frog.sv

// File: tb_frog.sv
`timescale 1ns/1ps

module tb_frog;

    typedef struct packed {
        logic [1:0]          code;
        logic [7:0]          hold;
        frog_pkg::coord_t    x;
        frog_pkg::coord_t    y;
        frog_pkg::score_t    score;
    } row_t;

    localparam int PIX_DIV      = frog_pkg::PIX_DIV;
    localparam int DEB          = frog_pkg::DEBOUNCE_CYCLES;
    localparam int H_BACK       = int'(frog_pkg::H_BACK);
    localparam int H_VISIBLE    = int'(frog_pkg::H_VISIBLE);
    localparam int H_SYNC       = int'(frog_pkg::H_SYNC);
    localparam int H_TOTAL      = int'(frog_pkg::H_TOTAL);
    localparam int V_BACK       = int'(frog_pkg::V_BACK);
    localparam int V_VISIBLE    = int'(frog_pkg::V_VISIBLE);
    localparam int V_SYNC       = int'(frog_pkg::V_SYNC);
    localparam int V_TOTAL      = int'(frog_pkg::V_TOTAL);
    localparam int RST_CYCLES   = 16;
    localparam int PRESS_HOLD   = DEB + 4;
    localparam int ROW_PERIOD   = PRESS_HOLD + DEB + 12;
    localparam int FRAME_CYCLES = PIX_DIV * H_TOTAL * V_TOTAL;
    localparam int LANE3_Y      = int'(frog_pkg::FIELD_Y0) + 3 * int'(frog_pkg::CELL) + 5;
    localparam int LANE8_Y      = int'(frog_pkg::FIELD_Y0) + 8 * int'(frog_pkg::CELL) + 5;
    localparam int N_PROBES     = 4;

    logic                sys_clk;
    logic                sys_rst_n;
    logic                left_btn;
    logic                right_btn;
    logic                hop_btn;
    logic                hsync;
    logic                vsync;
    frog_pkg::rgb_t      rgb;
    frog_pkg::frog_pos_t frog_pos;
    frog_pkg::score_t    score;

    row_t                stim_q[$];
    frog_pkg::frog_pos_t model_pos;
    frog_pkg::score_t    model_score;
    integer              seed = 32'ha27c;
    int                  err_cnt = 0;
    int                  cycle_cnt = 0;
    int                  cycle_limit = 0;

    // Probe points listed in scan order
    int             probe_x [N_PROBES] = '{10, 200, 400, int'(frog_pkg::START_X)};
    int             probe_y [N_PROBES] = '{100, LANE3_Y, LANE8_Y, int'(frog_pkg::START_Y)};
    frog_pkg::rgb_t probe_rgb [N_PROBES] = '{frog_pkg::WALL_COLOR, frog_pkg::RIVER_COLOR,
                                             frog_pkg::ROAD_COLOR, frog_pkg::FROG_COLOR};

    frog_top dut (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .left_btn  (left_btn),
        .right_btn (right_btn),
        .hop_btn   (hop_btn),
        .hsync     (hsync),
        .vsync     (vsync),
        .rgb       (rgb),
        .frog_pos  (frog_pos),
        .score     (score)
    );

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the test did not finish within %0d clock cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual !== expected) begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch");
        end
    endtask

    // Reference model where only a press held past the debounce window moves the frog
    task automatic add_rows(input logic [1:0] code, input int count, input bit glitch);
        row_t r;
        int   next_x;
        repeat (count) begin
            r.code = code;
            if (glitch) begin
                r.hold = 8'(1 + ($unsigned($random(seed)) % (DEB - 1)));
            end else begin
                r.hold = 8'(PRESS_HOLD);
            end
            if (int'(r.hold) >= DEB) begin
                if (code == 2'd3) begin
                    if (model_pos.y == frog_pkg::FIELD_Y0) begin
                        model_pos.x = frog_pkg::START_X;
                        model_pos.y = frog_pkg::START_Y;
                        model_score = model_score + 8'd1;
                    end else begin
                        model_pos.y = model_pos.y - frog_pkg::CELL;
                    end
                end else if (code == 2'd1) begin
                    // The whole frog box must stay right of the left wall
                    next_x = int'(model_pos.x) - int'(frog_pkg::CELL);
                    if (next_x >= int'(frog_pkg::FIELD_X0)) begin
                        model_pos.x = 10'(next_x);
                    end
                end else begin
                    next_x = int'(model_pos.x) + int'(frog_pkg::CELL);
                    if (next_x + int'(frog_pkg::FROG_SIZE) <= int'(frog_pkg::FIELD_X1)) begin
                        model_pos.x = 10'(next_x);
                    end
                end
            end
            r.x = model_pos.x;
            r.y = model_pos.y;
            r.score = model_score;
            stim_q.push_back(r);
        end
    endtask

    task automatic apply_row(input row_t r);
        @(posedge sys_clk);
        #1;
        left_btn  = (r.code == 2'd1);
        right_btn = (r.code == 2'd2);
        hop_btn   = (r.code == 2'd3);
        repeat (r.hold) @(posedge sys_clk);
        #1;
        left_btn  = 1'b0;
        right_btn = 1'b0;
        hop_btn   = 1'b0;
        // Let the release settle in the debouncer
        repeat (DEB + 10) @(posedge sys_clk);
        @(negedge sys_clk);
        check_value(int'(frog_pos.x), int'(r.x), "frog x");
        check_value(int'(frog_pos.y), int'(r.y), "frog y");
        check_value(int'(score), int'(r.score), "score");
    endtask

    task automatic wait_vsync_rise();
        logic vs_prev;
        @(negedge sys_clk);
        vs_prev = vsync;
        @(negedge sys_clk);
        while (!(vsync && !vs_prev)) begin
            vs_prev = vsync;
            @(negedge sys_clk);
        end
    endtask

    // Walks one frame from a vsync rise and locates pixels by counting from the sync rises
    task automatic scan_frame();
        int   rises = 0;
        int   cyc = 0;
        int   hs_low = 0;
        int   vs_low = 0;
        int   k = 0;
        logic hs_prev = hsync;
        logic vs_prev = vsync;
        bit   visible;
        bit   done = 1'b0;
        while (!done) begin
            @(negedge sys_clk);
            cyc++;
            if (!hsync) hs_low++;
            if (!vsync) vs_low++;
            if (hsync && !hs_prev) begin
                check_value(hs_low, PIX_DIV * H_SYNC, "hsync low width in cycles");
                hs_low = 0;
                cyc = 0;
                rises++;
            end
            if (vsync && !vs_prev) begin
                check_value(vs_low, PIX_DIV * H_TOTAL * V_SYNC, "vsync low width in cycles");
                check_value(rises, V_TOTAL, "hsync pulses per frame");
                done = 1'b1;
            end
            visible = rises >= V_BACK && rises < V_BACK + V_VISIBLE &&
                      cyc / PIX_DIV >= H_BACK && cyc / PIX_DIV < H_BACK + H_VISIBLE;
            if (!visible) check_value(int'(rgb), 0, "rgb during blanking");
            if (k < N_PROBES && rises == V_BACK + probe_y[k] &&
                cyc == PIX_DIV * (H_BACK + probe_x[k]) + 1) begin
                check_value(int'(rgb), int'(probe_rgb[k]), "probed pixel color");
                k++;
            end
            hs_prev = hsync;
            vs_prev = vsync;
        end
        check_value(k, N_PROBES, "number of probed pixels");
    endtask

    initial begin
        sys_rst_n   = 1'b0;
        left_btn    = 1'b0;
        right_btn   = 1'b0;
        hop_btn     = 1'b0;
        model_pos.x = frog_pkg::START_X;
        model_pos.y = frog_pkg::START_Y;
        model_score = '0;
        add_rows(2'd1, 1, 1'b1);
        add_rows(2'd2, 1, 1'b1);
        add_rows(2'd3, 1, 1'b1);
        // Start column is off the wall grid so each sweep stops half a cell from its wall
        add_rows(2'd1, 9, 1'b0);
        add_rows(2'd2, 16, 1'b0);
        add_rows(2'd1, 3, 1'b0);
        add_rows(2'd3, 13, 1'b0);
        add_rows(2'd3, 1, 1'b1);
        add_rows(2'd1, 1, 1'b1);
        add_rows(2'd3, 13, 1'b0);
        cycle_limit = RST_CYCLES + stim_q.size() * ROW_PERIOD + 3 * FRAME_CYCLES + 100;
        repeat (RST_CYCLES) @(posedge sys_clk);
        #1;
        sys_rst_n = 1'b1;
        @(negedge sys_clk);
        check_value(int'(frog_pos.x), int'(frog_pkg::START_X), "frog x after reset");
        check_value(int'(frog_pos.y), int'(frog_pkg::START_Y), "frog y after reset");
        check_value(int'(score), 0, "score after reset");
        check_value(int'(hsync), 1, "hsync after reset");
        check_value(int'(vsync), 1, "vsync after reset");
        check_value(int'(rgb), 0, "rgb after reset");
        foreach (stim_q[i]) begin
            apply_row(stim_q[i]);
        end
        wait_vsync_rise();
        scan_frame();
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
    input  logic             sys_clk,
    input  logic             sys_rst_n,
    output frog_pkg::pixel_t pix
);

    logic [frog_pkg::DIV_W-1:0] div_cnt;
    logic                       p_tick;
    frog_pkg::coord_t           h_cnt;
    frog_pkg::coord_t           v_cnt;
    logic                       h_end;
    logic                       v_end;

    // One pixel every PIX_DIV system clocks
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign p_tick = (div_cnt == frog_pkg::DIV_W'(frog_pkg::PIX_DIV - 1));
    assign h_end  = (h_cnt == frog_pkg::H_TOTAL - 10'd1);
    assign v_end  = (v_cnt == frog_pkg::V_TOTAL - 10'd1);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (p_tick) begin
            if (h_end) begin
                h_cnt <= '0;
                // Line advances at the end of each scan line
                if (v_end) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    assign pix.x        = h_cnt;
    assign pix.y        = v_cnt;
    assign pix.p_tick   = p_tick;
    assign pix.video_on = (h_cnt < frog_pkg::H_VISIBLE) && (v_cnt < frog_pkg::V_VISIBLE);

    // Sync pulses sit after the front porch, active low
    assign pix.hsync = !((h_cnt >= frog_pkg::H_VISIBLE + frog_pkg::H_FRONT) &&
                         (h_cnt <  frog_pkg::H_VISIBLE + frog_pkg::H_FRONT + frog_pkg::H_SYNC));
    assign pix.vsync = !((v_cnt >= frog_pkg::V_VISIBLE + frog_pkg::V_FRONT) &&
                         (v_cnt <  frog_pkg::V_VISIBLE + frog_pkg::V_FRONT + frog_pkg::V_SYNC));

endmodule
